// ==== hdl/padctrl_params.svh ====
////////////////////////////////////////
// Pad counts, register map and JTAG pad indices for the pad
// subsystem. Include wherever these constants are needed.
////////////////////////////////////////
`ifndef PADCTRL_PARAMS_SVH
`define PADCTRL_PARAMS_SVH

// Pad counts
`define PADCTRL_NMIO 8
`define PADCTRL_NDIO 6
`define PADCTRL_ATTR_DW 2 // Bit 0 invert, bit 1 open-drain

// Configuration port widths
`define PADCTRL_CFG_AW 5
`define PADCTRL_CFG_DW 8

// Register map, word addresses
`define PADCTRL_ADDR_MIO0 5'd0  // MIO attributes 0..7
`define PADCTRL_ADDR_DIO0 5'd8  // DIO attributes 8..13
`define PADCTRL_ADDR_JTAG 5'd14 // JTAG permit bit

// JTAG strap on MIO, JTAG port on DIO
`define PADCTRL_JTAG_EN_IDX 6
`define PADCTRL_TCK_IDX 0
`define PADCTRL_TMS_IDX 1
`define PADCTRL_TDI_IDX 2
`define PADCTRL_TDO_IDX 3

`endif

// ==== hdl/padctrl_pkg.sv ====
////////////////////////////////////////
// Shared types of the pad subsystem: pad vectors, core-side buses,
// pad attributes, configuration port and JTAG signals
////////////////////////////////////////
`default_nettype none

`include "padctrl_params.svh"

package padctrl_pkg;

  // One bit per pad
  typedef logic [`PADCTRL_NMIO-1:0] mio_vec_t;
  typedef logic [`PADCTRL_NDIO-1:0] dio_vec_t;

  // Core drive toward the pads
  typedef struct packed {
    mio_vec_t out;
    mio_vec_t oe;
  } mio_bus_t;

  typedef struct packed {
    dio_vec_t out;
    dio_vec_t oe;
  } dio_bus_t;

  // Per-pad attribute, invert sits in bit 0
  typedef struct packed {
    logic open_drain;
    logic invert;
  } pad_attr_t;

  typedef pad_attr_t [`PADCTRL_NMIO-1:0] mio_attr_t;
  typedef pad_attr_t [`PADCTRL_NDIO-1:0] dio_attr_t;

  //////////////////////////////////////
  // Configuration port, four-phase req/ack
  //////////////////////////////////////
  typedef struct packed {
    logic                       req;
    logic                       we;
    logic [`PADCTRL_CFG_AW-1:0] addr;
    logic [`PADCTRL_CFG_DW-1:0] wdata;
  } cfg_req_t;

  typedef struct packed {
    logic                       ack;
    logic [`PADCTRL_CFG_DW-1:0] rdata;
  } cfg_rsp_t;

  // JTAG signals toward the core TAP
  typedef struct packed {
    logic tck;
    logic tms;
    logic tdi;
    logic trst_n;
  } jtag_req_t;

endpackage

`default_nettype wire

// ==== hdl/padctrl_regs.sv ====
////////////////////////////////////////
// Pad configuration registers: one attribute per pad plus the JTAG
// permit bit, accessed through a four-phase req/ack port
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "padctrl_params.svh"

module padctrl_regs import padctrl_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  // Configuration port
  input  cfg_req_t  cfg_req_i,
  output cfg_rsp_t  cfg_rsp_o,
  // To pad logic
  output mio_attr_t mio_attr_o,
  output dio_attr_t dio_attr_o,
  output logic      jtag_permit_o
);

  typedef enum logic {
    st_idle,
    st_ack
  } ack_state_e;

  ack_state_e                 state_q, state_d;
  logic                       access;     // Accepted request this cycle
  mio_attr_t                  mio_attr_q;
  dio_attr_t                  dio_attr_q;
  logic                       permit_q;
  logic [`PADCTRL_CFG_DW-1:0] rdata_d, rdata_q;
  pad_attr_t                  wr_attr;

  //////////////////////////////////////
  // Handshake FSM
  //////////////////////////////////////

  // Idle waits for req, ack waits for req to drop
  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle: if (cfg_req_i.req) state_d = st_ack;
      st_ack:  if (!cfg_req_i.req) state_d = st_idle;
      default: state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  assign access = (state_q == st_idle) && cfg_req_i.req;

  //////////////////////////////////////
  // Register writes
  //////////////////////////////////////

  assign wr_attr = pad_attr_t'(cfg_req_i.wdata[`PADCTRL_ATTR_DW-1:0]);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mio_attr_q <= '0;
      dio_attr_q <= '0;
      permit_q   <= 1'b0;
    end else if (access && cfg_req_i.we) begin
      for (int i = 0; i < `PADCTRL_NMIO; i++) begin
        if (cfg_req_i.addr == `PADCTRL_ADDR_MIO0 + `PADCTRL_CFG_AW'(i)) begin
          mio_attr_q[i] <= wr_attr;
        end
      end
      for (int i = 0; i < `PADCTRL_NDIO; i++) begin
        if (cfg_req_i.addr == `PADCTRL_ADDR_DIO0 + `PADCTRL_CFG_AW'(i)) begin
          dio_attr_q[i] <= wr_attr;
        end
      end
      if (cfg_req_i.addr == `PADCTRL_ADDR_JTAG) begin
        permit_q <= cfg_req_i.wdata[0];
      end
    end
  end

  //////////////////////////////////////
  // Read data
  //////////////////////////////////////

  // Unmapped addresses fall through as zero
  always_comb begin
    rdata_d = '0;
    for (int i = 0; i < `PADCTRL_NMIO; i++) begin
      if (cfg_req_i.addr == `PADCTRL_ADDR_MIO0 + `PADCTRL_CFG_AW'(i)) begin
        rdata_d = {{(`PADCTRL_CFG_DW-`PADCTRL_ATTR_DW){1'b0}}, mio_attr_q[i]};
      end
    end
    for (int i = 0; i < `PADCTRL_NDIO; i++) begin
      if (cfg_req_i.addr == `PADCTRL_ADDR_DIO0 + `PADCTRL_CFG_AW'(i)) begin
        rdata_d = {{(`PADCTRL_CFG_DW-`PADCTRL_ATTR_DW){1'b0}}, dio_attr_q[i]};
      end
    end
    if (cfg_req_i.addr == `PADCTRL_ADDR_JTAG) begin
      rdata_d = {{(`PADCTRL_CFG_DW-1){1'b0}}, permit_q};
    end
  end

  // Captured with the access, held while ack is high
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rdata_q <= '0;
    end else if (access && !cfg_req_i.we) begin
      rdata_q <= rdata_d;
    end
  end

  assign cfg_rsp_o.ack   = (state_q == st_ack);
  assign cfg_rsp_o.rdata = rdata_q;

  assign mio_attr_o    = mio_attr_q;
  assign dio_attr_o    = dio_attr_q;
  assign jtag_permit_o = permit_q;

endmodule

`default_nettype wire

// ==== hdl/jtag_overlay_mux.sv ====
////////////////////////////////////////
// JTAG overlay on the dedicated pads. Active when the synchronized
// strap pad and the permit bit are both high
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "padctrl_params.svh"

module jtag_overlay_mux import padctrl_pkg::*; (
  input  logic      jtag_permit_i,
  // Core side
  input  mio_bus_t  mio_core_i,
  input  dio_bus_t  dio_core_i,
  output mio_vec_t  mio_core_in_o,
  output dio_vec_t  dio_core_in_o,
  // Pad side
  input  mio_vec_t  mio_in_sync_i,
  input  dio_vec_t  dio_in_sync_i,
  output mio_bus_t  mio_pad_o,
  output dio_bus_t  dio_pad_o,
  // JTAG TAP
  input  logic      jtag_tdo_i,
  output jtag_req_t jtag_o
);

  logic strap;
  logic jtag_active;

  assign strap       = mio_in_sync_i[`PADCTRL_JTAG_EN_IDX];
  assign jtag_active = strap & jtag_permit_i;

  // MIO is never overlaid
  assign mio_pad_o     = mio_core_i;
  assign mio_core_in_o = mio_in_sync_i;

  //////////////////////////////////////
  // Pad-side drive
  //////////////////////////////////////

  always_comb begin
    dio_pad_o = dio_core_i;
    if (jtag_active) begin
      // TCK, TMS, TDI become inputs
      dio_pad_o.out[`PADCTRL_TCK_IDX] = 1'b0;
      dio_pad_o.oe[`PADCTRL_TCK_IDX]  = 1'b0;
      dio_pad_o.out[`PADCTRL_TMS_IDX] = 1'b0;
      dio_pad_o.oe[`PADCTRL_TMS_IDX]  = 1'b0;
      dio_pad_o.out[`PADCTRL_TDI_IDX] = 1'b0;
      dio_pad_o.oe[`PADCTRL_TDI_IDX]  = 1'b0;
      dio_pad_o.out[`PADCTRL_TDO_IDX] = jtag_tdo_i; // TDO drives its pad
      dio_pad_o.oe[`PADCTRL_TDO_IDX]  = 1'b1;
    end
  end

  //////////////////////////////////////
  // Core-side inputs
  //////////////////////////////////////

  // Tie-offs seen by the core while JTAG owns the pads
  always_comb begin
    dio_core_in_o = dio_in_sync_i;
    if (jtag_active) begin
      dio_core_in_o[`PADCTRL_TCK_IDX] = 1'b0;
      dio_core_in_o[`PADCTRL_TMS_IDX] = 1'b1; // Inactive level
      dio_core_in_o[`PADCTRL_TDI_IDX] = 1'b0;
      dio_core_in_o[`PADCTRL_TDO_IDX] = 1'b0;
    end
  end

  //////////////////////////////////////
  // TAP inputs
  //////////////////////////////////////

  // Idle TAP sees TMS high and a quiet clock
  assign jtag_o.tck    = jtag_active & dio_in_sync_i[`PADCTRL_TCK_IDX];
  assign jtag_o.tms    = jtag_active ? dio_in_sync_i[`PADCTRL_TMS_IDX] : 1'b1;
  assign jtag_o.tdi    = jtag_active & dio_in_sync_i[`PADCTRL_TDI_IDX];
  assign jtag_o.trst_n = strap; // TAP held in reset without the strap

endmodule

`default_nettype wire

// ==== hdl/pad_cell_array.sv ====
////////////////////////////////////////
// Behavioral pad cells with inversion, open-drain and a two-flop
// input synchronizer. Used once per pad group via pad_vec_t
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module pad_cell_array import padctrl_pkg::*; #(
  parameter type pad_vec_t = mio_vec_t
) (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  // Core side
  input  pad_vec_t                           out_i,
  input  pad_vec_t                           oe_i,
  input  pad_attr_t [$bits(pad_vec_t)-1:0]   attr_i,
  output pad_vec_t                           in_sync_o,
  // Pad side
  input  pad_vec_t                           pad_in_i,
  output pad_vec_t                           pad_out_o,
  output pad_vec_t                           pad_oe_o
);

  localparam int n_pads = $bits(pad_vec_t);

  pad_vec_t inv_mask;  // Per-pad invert bits
  pad_vec_t od_mask;   // Per-pad open-drain bits
  pad_vec_t drv_val;
  pad_vec_t in_q1, in_q2;

  always_comb begin
    for (int i = 0; i < n_pads; i++) begin
      inv_mask[i] = attr_i[i].invert;
      od_mask[i]  = attr_i[i].open_drain;
    end
  end

  //////////////////////////////////////
  // Output path
  //////////////////////////////////////

  assign drv_val = pad_vec_t'(out_i ^ inv_mask);

  // Open drain only pulls low, a 1 releases the pad
  assign pad_out_o = pad_vec_t'(drv_val & ~od_mask);
  assign pad_oe_o  = pad_vec_t'(oe_i & ~(od_mask & drv_val));

  //////////////////////////////////////
  // Input path
  //////////////////////////////////////

  // Two-flop synchronizer after inversion
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      in_q1 <= '0;
      in_q2 <= '0;
    end else begin
      in_q1 <= pad_vec_t'(pad_in_i ^ inv_mask);
      in_q2 <= in_q1;
    end
  end

  assign in_sync_o = in_q2;

endmodule

`default_nettype wire

// ==== hdl/pad_subsystem_top.sv ====
////////////////////////////////////////
// Chip-edge I/O subsystem top: configuration registers, JTAG overlay
// and the MIO and DIO pad cell arrays
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module pad_subsystem_top import padctrl_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  // Configuration port
  input  cfg_req_t  cfg_req_i,
  output cfg_rsp_t  cfg_rsp_o,
  // Core side
  input  mio_bus_t  mio_core_i,
  input  dio_bus_t  dio_core_i,
  output mio_vec_t  mio_core_in_o,
  output dio_vec_t  dio_core_in_o,
  output jtag_req_t jtag_o,
  input  logic      jtag_tdo_i,
  // Pads, split into in/out/oe
  input  mio_vec_t  mio_pad_in_i,
  output mio_vec_t  mio_pad_out_o,
  output mio_vec_t  mio_pad_oe_o,
  input  dio_vec_t  dio_pad_in_i,
  output dio_vec_t  dio_pad_out_o,
  output dio_vec_t  dio_pad_oe_o
);

  mio_attr_t mio_attr;
  dio_attr_t dio_attr;
  logic      jtag_permit;
  mio_vec_t  mio_in_sync;
  dio_vec_t  dio_in_sync;
  mio_bus_t  mio_pad_bus;
  dio_bus_t  dio_pad_bus;

  //////////////////////////////////////
  // Registers and overlay
  //////////////////////////////////////

  padctrl_regs u_regs (
    .clk_i         ( clk_i       ),
    .rst_n_i       ( rst_n_i     ),
    .cfg_req_i     ( cfg_req_i   ),
    .cfg_rsp_o     ( cfg_rsp_o   ),
    .mio_attr_o    ( mio_attr    ),
    .dio_attr_o    ( dio_attr    ),
    .jtag_permit_o ( jtag_permit )
  );

  jtag_overlay_mux u_jtag_mux (
    .jtag_permit_i ( jtag_permit   ),
    .mio_core_i    ( mio_core_i    ),
    .dio_core_i    ( dio_core_i    ),
    .mio_core_in_o ( mio_core_in_o ),
    .dio_core_in_o ( dio_core_in_o ),
    .mio_in_sync_i ( mio_in_sync   ),
    .dio_in_sync_i ( dio_in_sync   ),
    .mio_pad_o     ( mio_pad_bus   ),
    .dio_pad_o     ( dio_pad_bus   ),
    .jtag_tdo_i    ( jtag_tdo_i    ),
    .jtag_o        ( jtag_o        )
  );

  //////////////////////////////////////
  // Pad cells
  //////////////////////////////////////

  pad_cell_array #(
    .pad_vec_t ( mio_vec_t )
  ) u_mio_pads (
    .clk_i     ( clk_i           ),
    .rst_n_i   ( rst_n_i         ),
    .out_i     ( mio_pad_bus.out ),
    .oe_i      ( mio_pad_bus.oe  ),
    .attr_i    ( mio_attr        ),
    .in_sync_o ( mio_in_sync     ),
    .pad_in_i  ( mio_pad_in_i    ),
    .pad_out_o ( mio_pad_out_o   ),
    .pad_oe_o  ( mio_pad_oe_o    )
  );

  pad_cell_array #(
    .pad_vec_t ( dio_vec_t )
  ) u_dio_pads (
    .clk_i     ( clk_i           ),
    .rst_n_i   ( rst_n_i         ),
    .out_i     ( dio_pad_bus.out ),
    .oe_i      ( dio_pad_bus.oe  ),
    .attr_i    ( dio_attr        ),
    .in_sync_o ( dio_in_sync     ),
    .pad_in_i  ( dio_pad_in_i    ),
    .pad_out_o ( dio_pad_out_o   ),
    .pad_oe_o  ( dio_pad_oe_o    )
  );

endmodule

`default_nettype wire

// ==== testbench/pad_checker.sv ====
////////////////////////////////////////
// Testbench checker for the pad subsystem. Shadows the register writes
// and compares pad and core-side values on request from the testbench
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "padctrl_params.svh"

module pad_checker import padctrl_pkg::*; (
  input logic      clk_i,
  input logic      rst_n_i,
  input cfg_req_t  cfg_req_i,
  input cfg_rsp_t  cfg_rsp_i,
  input mio_bus_t  mio_core_i,
  input dio_bus_t  dio_core_i,
  input mio_vec_t  mio_core_in_i,
  input dio_vec_t  dio_core_in_i,
  input jtag_req_t jtag_i,
  input logic      jtag_tdo_i,
  input mio_vec_t  mio_pad_in_i,
  input mio_vec_t  mio_pad_out_i,
  input mio_vec_t  mio_pad_oe_i,
  input dio_vec_t  dio_pad_out_i,
  input dio_vec_t  dio_pad_oe_i
);

  int         err_count;
  logic [1:0] mio_attr_s [`PADCTRL_NMIO]; // {open_drain, invert}
  logic [1:0] dio_attr_s [`PADCTRL_NDIO];
  logic       permit_s;

  initial err_count = 0;

  ////////////////////////////////////////
  // Shadow of the register map
  ////////////////////////////////////////

  // A write lands when req is seen with ack still low
  always @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `PADCTRL_NMIO; i++) begin
        mio_attr_s[i] <= 2'b00;
      end
      for (int i = 0; i < `PADCTRL_NDIO; i++) begin
        dio_attr_s[i] <= 2'b00;
      end
      permit_s <= 1'b0;
    end else if (cfg_req_i.req && cfg_req_i.we && !cfg_rsp_i.ack) begin
      if (cfg_req_i.addr < `PADCTRL_ADDR_DIO0) begin
        mio_attr_s[cfg_req_i.addr - `PADCTRL_ADDR_MIO0] <= cfg_req_i.wdata[1:0];
      end else if (cfg_req_i.addr < `PADCTRL_ADDR_DIO0 + `PADCTRL_NDIO) begin
        dio_attr_s[cfg_req_i.addr - `PADCTRL_ADDR_DIO0] <= cfg_req_i.wdata[1:0];
      end else if (cfg_req_i.addr == `PADCTRL_ADDR_JTAG) begin
        permit_s <= cfg_req_i.wdata[0];
      end
    end
  end

  task automatic report(input logic [8*24-1:0] name, input logic [8*40-1:0] msg);
    err_count++;
    $display("ERROR: %0s: %0s", name, msg);
  endtask

  task automatic compare(input logic [8*24-1:0] name, input logic [8*16-1:0] what,
                         input logic [7:0] exp, input logic [7:0] act);
    if (exp !== act) begin
      err_count++;
      $display("MISMATCH %0s %0s expected %h actual %h", name, what, exp, act);
    end
  endtask

  // Returns {oe, out} seen at one pad
  function automatic logic [1:0] pad_expect(input logic out, input logic oe,
                                            input logic inv, input logic od);
    logic v;
    logic p_out;
    logic p_oe;
    v     = out ^ inv;
    p_out = v;
    p_oe  = oe;
    if (od) begin
      p_out = 1'b0;
      if (v) p_oe = 1'b0; // Released, never driven high
    end
    return {p_oe, p_out};
  endfunction

  task automatic check_rdata(input logic [8*24-1:0] name, input logic [7:0] exp);
    compare(name, "rdata", exp, cfg_rsp_i.rdata);
  endtask

  ////////////////////////////////////////
  // Pad and core-side comparison
  ////////////////////////////////////////

  task automatic check_step(input logic [8*24-1:0] name, input logic [7:0] exp_mio_in,
                            input logic [7:0] exp_dio_in, input logic [3:0] exp_jtag);
    mio_vec_t   e_mio_out;
    mio_vec_t   e_mio_oe;
    dio_vec_t   e_dio_out;
    dio_vec_t   e_dio_oe;
    logic       active;
    logic       d_out;
    logic       d_oe;
    logic [1:0] r;
    active = (mio_pad_in_i[`PADCTRL_JTAG_EN_IDX] ^ mio_attr_s[`PADCTRL_JTAG_EN_IDX][0])
             & permit_s;
    for (int i = 0; i < `PADCTRL_NMIO; i++) begin
      r = pad_expect(mio_core_i.out[i], mio_core_i.oe[i], mio_attr_s[i][0], mio_attr_s[i][1]);
      e_mio_out[i] = r[0];
      e_mio_oe[i]  = r[1];
    end
    for (int i = 0; i < `PADCTRL_NDIO; i++) begin
      d_out = dio_core_i.out[i];
      d_oe  = dio_core_i.oe[i];
      if (active && (i == `PADCTRL_TCK_IDX || i == `PADCTRL_TMS_IDX ||
                     i == `PADCTRL_TDI_IDX)) begin
        d_out = 1'b0;
        d_oe  = 1'b0;
      end else if (active && i == `PADCTRL_TDO_IDX) begin
        d_out = jtag_tdo_i;
        d_oe  = 1'b1;
      end
      r = pad_expect(d_out, d_oe, dio_attr_s[i][0], dio_attr_s[i][1]);
      e_dio_out[i] = r[0];
      e_dio_oe[i]  = r[1];
    end
    compare(name, "mio_pad_out", e_mio_out, mio_pad_out_i);
    compare(name, "mio_pad_oe", e_mio_oe, mio_pad_oe_i);
    compare(name, "dio_pad_out", {2'b00, e_dio_out}, {2'b00, dio_pad_out_i});
    compare(name, "dio_pad_oe", {2'b00, e_dio_oe}, {2'b00, dio_pad_oe_i});
    compare(name, "mio_core_in", exp_mio_in, mio_core_in_i);
    compare(name, "dio_core_in", exp_dio_in, {2'b00, dio_core_in_i});
    compare(name, "jtag", {4'h0, exp_jtag}, {4'h0, jtag_i});
  endtask

endmodule

`default_nettype wire

// ==== testbench/tb_pad_subsystem.sv ====
////////////////////////////////////////
// Testbench top for the pad subsystem. Runs one test per line of
// testbench/pad_input.txt and prints a summary at the end
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "padctrl_params.svh"

module tb_pad_subsystem import padctrl_pkg::*; ();

  logic              clk;
  logic              rst_n;
  cfg_req_t          cfg_req;
  cfg_rsp_t          cfg_rsp;
  mio_bus_t          mio_core;
  dio_bus_t          dio_core;
  mio_vec_t          mio_core_in, mio_pad_in, mio_pad_out, mio_pad_oe;
  dio_vec_t          dio_core_in, dio_pad_in, dio_pad_out, dio_pad_oe;
  jtag_req_t         jtag;
  logic              jtag_tdo;
  // One line of the stimulus file
  int                fd, code, op;
  int                n_pass, n_fail, errs_before;
  logic [8*24-1:0]   name;
  logic [8*128-1:0]  skip_line;
  logic [7:0]        addr, wdata, rdata, mio_out, mio_oe, dio_out, dio_oe;
  logic [7:0]        mio_pin, dio_pin, exp_mio, exp_dio;
  logic              tdo;
  logic [3:0]        exp_jtag;

  initial clk = 1'b0;
  always #5 clk = ~clk;

  pad_subsystem_top u_dut (
    .clk_i (clk), .rst_n_i (rst_n), .cfg_req_i (cfg_req), .cfg_rsp_o (cfg_rsp),
    .mio_core_i (mio_core), .dio_core_i (dio_core), .mio_core_in_o (mio_core_in),
    .dio_core_in_o (dio_core_in), .jtag_o (jtag), .jtag_tdo_i (jtag_tdo),
    .mio_pad_in_i (mio_pad_in), .mio_pad_out_o (mio_pad_out), .mio_pad_oe_o (mio_pad_oe),
    .dio_pad_in_i (dio_pad_in), .dio_pad_out_o (dio_pad_out), .dio_pad_oe_o (dio_pad_oe)
  );

  pad_checker u_checker (
    .clk_i (clk), .rst_n_i (rst_n), .cfg_req_i (cfg_req), .cfg_rsp_i (cfg_rsp),
    .mio_core_i (mio_core), .dio_core_i (dio_core), .mio_core_in_i (mio_core_in),
    .dio_core_in_i (dio_core_in), .jtag_i (jtag), .jtag_tdo_i (jtag_tdo),
    .mio_pad_in_i (mio_pad_in), .mio_pad_out_i (mio_pad_out), .mio_pad_oe_i (mio_pad_oe),
    .dio_pad_out_i (dio_pad_out), .dio_pad_oe_i (dio_pad_oe)
  );

  ////////////////////////////////////////
  // Four-phase configuration access
  ////////////////////////////////////////

  task automatic cfg_access(input logic we, input logic [4:0] a, input logic [7:0] d,
                            input logic [7:0] exp, input logic [8*24-1:0] tname);
    int cnt;
    if (cfg_rsp.ack) u_checker.report(tname, "ack high before req");
    cfg_req.we    = we;
    cfg_req.addr  = a;
    cfg_req.wdata = d;
    cfg_req.req   = 1'b1;
    cnt = 0;
    @(negedge clk);
    while (!cfg_rsp.ack && cnt < 50) begin
      @(negedge clk);
      cnt++;
    end
    if (!cfg_rsp.ack) begin
      $display("ERROR: %0s: timeout waiting for ack rise", tname);
      $display("FAIL: see errors above");
      $finish;
    end
    if (!we) u_checker.check_rdata(tname, exp); // rdata valid while ack high
    // Ack holds as long as req stays high
    @(negedge clk);
    if (!cfg_rsp.ack) u_checker.report(tname, "ack fell while req was high");
    cfg_req.req = 1'b0;
    cnt = 0;
    @(negedge clk);
    while (cfg_rsp.ack && cnt < 50) begin
      @(negedge clk);
      cnt++;
    end
    if (cfg_rsp.ack) begin
      $display("ERROR: %0s: timeout waiting for ack fall", tname);
      $display("FAIL: see errors above");
      $finish;
    end
  endtask

  initial begin
    rst_n      = 1'b0;
    cfg_req    = '0;
    mio_core   = '0;
    dio_core   = '0;
    jtag_tdo   = 1'b0;
    mio_pad_in = '0;
    dio_pad_in = '0;
    n_pass     = 0;
    n_fail     = 0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    if (cfg_rsp.ack) u_checker.report("reset", "ack high after reset");
    fd = $fopen("testbench/pad_input.txt", "r");
    if (fd == 0) begin
      $display("ERROR: cannot open testbench/pad_input.txt");
      $display("FAIL: see errors above");
      $finish;
    end
    while (!$feof(fd)) begin
      code = $fscanf(fd, "%s", name);
      if (code != 1) break;
      if (name == "#") begin
        code = $fgets(skip_line, fd); // Column description
      end else begin
        code = $fscanf(fd, "%d %h %h %h %h %h %h %h %h %h %h %h %h %h", op, addr, wdata,
                       rdata, mio_out, mio_oe, dio_out, dio_oe, mio_pin, dio_pin, tdo,
                       exp_mio, exp_dio, exp_jtag);
        if (code != 14) u_checker.report(name, "malformed stimulus line");
        errs_before = u_checker.err_count;
        if (op == 1 || op == 3) cfg_access(1'b1, addr[4:0], wdata, 8'h00, name);
        if (op == 2 || op == 3) cfg_access(1'b0, addr[4:0], 8'h00, rdata, name);
        mio_core.out = mio_out;
        mio_core.oe  = mio_oe;
        dio_core.out = dio_out[`PADCTRL_NDIO-1:0];
        dio_core.oe  = dio_oe[`PADCTRL_NDIO-1:0];
        mio_pad_in   = mio_pin;
        dio_pad_in   = dio_pin[`PADCTRL_NDIO-1:0];
        jtag_tdo     = tdo;
        // Pad inputs need two edges through the synchronizer
        repeat (2) @(posedge clk);
        @(negedge clk);
        u_checker.check_step(name, exp_mio, exp_dio, exp_jtag);
        if (u_checker.err_count == errs_before) begin
          n_pass++;
          $display("test %0s: ok", name);
        end else begin
          n_fail++;
          $display("test %0s: failed", name);
        end
      end
    end
    $fclose(fd);
    $display("tests: %0d passed, %0d failed, %0d errors", n_pass, n_fail,
             u_checker.err_count);
    if (u_checker.err_count == 0 && n_fail == 0 && n_pass > 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+hdl
hdl/padctrl_pkg.sv
hdl/padctrl_regs.sv
hdl/jtag_overlay_mux.sv
hdl/pad_cell_array.sv
hdl/pad_subsystem_top.sv
testbench/pad_checker.sv
testbench/tb_pad_subsystem.sv

// ==== testbench/pad_input.txt ====
# name op(0 none 1 wr 2 rd 3 wr+rd) addr wdata rdata mio_out mio_oe dio_out dio_oe
# mio_pad dio_pad tdo then expected mio_core_in dio_core_in jtag{tck,tms,tdi,trst_n}
reset_rd_mio3 2 03 00 00 a5 ff 2a 3f 00 00 0 00 00 4
reset_rd_dio4 2 0c 00 00 3c 0f 15 3c 5a 11 0 5a 11 5
reset_rd_jtag 2 0e 00 00 00 00 00 00 00 00 0 00 00 4
attr_mio0 3 00 01 01 ff ff 3f 3f 00 00 0 01 00 4
attr_mio1 3 01 02 02 ff ff 3f 3f 00 00 0 01 00 4
attr_mio2 3 02 03 03 ff ff 3f 3f 00 00 0 05 00 4
attr_mio3 3 03 fc 00 ff ff 3f 3f 00 00 0 05 00 4
attr_mio4 3 04 01 01 ff ff 3f 3f 00 00 0 15 00 4
attr_mio5 3 05 02 02 ff ff 3f 3f 00 00 0 15 00 4
attr_mio6 3 06 00 00 ff ff 3f 3f 00 00 0 15 00 4
attr_mio7 3 07 03 03 ff ff 3f 3f 00 00 0 95 00 4
attr_dio0 3 08 01 01 ff ff 3f 3f 00 00 0 95 01 4
attr_dio1 3 09 02 02 ff ff 3f 3f 00 00 0 95 01 4
attr_dio2 3 0a 03 03 ff ff 3f 3f 00 00 0 95 05 4
attr_dio3 3 0b 01 01 ff ff 3f 3f 00 00 0 95 0d 4
attr_dio4 3 0c 02 02 ff ff 3f 3f 00 00 0 95 0d 4
attr_dio5 3 0d ff 03 ff ff 3f 3f 00 00 0 95 2d 4
attr_jtag 3 0e 01 01 ff ff 3f 3f 00 00 0 95 2d 4
unmap_0f 3 0f ff 00 ff ff 3f 3f 00 00 0 95 2d 4
unmap_1f 2 1f 00 00 ff ff 3f 3f 00 00 0 95 2d 4
invert_a 0 00 00 00 0f ff 3f 3f 0f 15 0 9a 38 4
invert_b 0 00 00 00 f0 ff 00 3f 33 2a 0 a6 07 4
open_drain_a 0 00 00 00 ff ff 00 3f 00 00 0 95 2d 4
open_drain_b 0 00 00 00 55 aa 3f 15 84 3f 0 11 12 4
jtag_no_permit 1 0e 00 00 00 ff 15 3f 40 07 1 d5 2a 5
jtag_permit_on 3 0e 01 01 00 ff 15 3f 40 18 1 d5 32 b
jtag_tdo_low 0 00 00 00 00 ff 15 3f 40 3d 0 d5 12 1
jtag_tms_high 0 00 00 00 00 ff 15 3f 40 06 1 d5 22 d
strap_removed 0 00 00 00 00 ff 15 3f 00 18 0 95 35 4
strap_permit_off 1 0e 00 00 00 ff 15 3f 40 18 0 d5 35 5
